//--- bench/alignerStimulus.txt
# C mask lane0 lane1 lane2 lane3 grab hold : mask and words in hex, hold in cycles
# F mask : expected laneAlmostFull, T sets left0 left1 left2 left3 : closing totals
# Gating, lane 3 stays empty for a while
C 7 01 11 21 00 0 3
C 0 00 00 00 00 0 12
C 8 00 00 00 31 0 3
C 0 00 00 00 00 0 20
C 0 00 00 00 00 1 20
# Lane 0 written 24 words above the others
C 1 40 00 00 00 0 24
C 0 00 00 00 00 0 10
F 1
C E 00 50 60 70 0 24
C 0 00 00 00 00 0 10
C 0 00 00 00 00 1 130
F 0
# Back-pressure with grab low for a long stretch
C F 80 90 A0 B0 0 20
C 0 00 00 00 00 0 30
C F C0 D0 E0 F0 0 12
C 0 00 00 00 00 0 10
C 0 00 00 00 00 1 160
# Single grab pulses on consecutive sets
C F 10 20 30 40 0 4
C 0 00 00 00 00 0 20
C 0 00 00 00 00 1 1
C 0 00 00 00 00 0 4
C 0 00 00 00 00 1 1
C 0 00 00 00 00 0 4
C 0 00 00 00 00 1 1
C 0 00 00 00 00 0 4
C 0 00 00 00 00 1 1
C 0 00 00 00 00 0 4
# Leftover words on lane 2
C 4 00 00 77 00 0 3
C 0 00 00 00 00 0 12
T 63 0 0 3 0

//--- tb.f
src/fifoGeometryPkg.sv
src/laneStreamPkg.sv
src/fifoMemory.sv
src/streamSynchronizer.sv
src/fastFifo.sv
src/fifoOutputReg.sv
src/laneAligner.sv
bench/alignerChecker.sv
bench/laneAlignerTb.sv

//--- Bender.yml
package:
  name: lane_aligner

sources:
  - src/fifoGeometryPkg.sv
  - src/laneStreamPkg.sv
  - src/fifoMemory.sv
  - src/streamSynchronizer.sv
  - src/fastFifo.sv
  - src/fifoOutputReg.sv
  - src/laneAligner.sv
  - target: test
    files:
      - bench/alignerChecker.sv
      - bench/laneAlignerTb.sv

//--- bench/laneAlignerTb.sv
`timescale 1ns/1ns

module laneAlignerTb
    import laneStreamPkg::*;
();

    typedef struct packed {
        logic        isFlag;
        laneMask_t   mask;
        laneSet_t    words;
        logic        grab;
        logic [15:0] hold;
    } command_t;

    logic clk;
    logic rst;
    laneMask_t laneWrite;
    laneSet_t laneData;
    logic grab;
    laneMask_t laneAlmostFull;
    logic setAvailable;
    laneSet_t setOut;

    logic flagCheck;
    laneMask_t flagExpect;
    logic endCheck;
    int expectSets;
    logic [NUM_LANES-1:0][15:0] expectLeft;
    int dataErrors;
    int gatingErrors;
    int flagErrors;
    int endErrors;
    int fileErrors;

    int cycleCount;
    int cycleLimit;
    logic limitReady;
    command_t commands[$];

    laneAligner u_dut (
        .clk(clk),
        .rst(rst),
        .laneWrite(laneWrite),
        .laneData(laneData),
        .laneAlmostFull(laneAlmostFull),
        .grab(grab),
        .setAvailable(setAvailable),
        .setOut(setOut)
    );

    alignerChecker watcher (
        .clk(clk),
        .rst(rst),
        .laneWrite(laneWrite),
        .laneData(laneData),
        .laneAlmostFull(laneAlmostFull),
        .grab(grab),
        .setAvailable(setAvailable),
        .setOut(setOut),
        .flagCheck(flagCheck),
        .flagExpect(flagExpect),
        .endCheck(endCheck),
        .expectSets(expectSets),
        .expectLeft(expectLeft),
        .dataErrors(dataErrors),
        .gatingErrors(gatingErrors),
        .flagErrors(flagErrors),
        .endErrors(endErrors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (limitReady && cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic loadStimulus();
        int fd;
        int n;
        int i;
        int mask;
        int g;
        int h;
        int w [NUM_LANES];
        int left [NUM_LANES];
        logic haveTotal;
        string line;
        command_t cmd;
        haveTotal = 1'b0;
        fd = $fopen("bench/alignerStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file bench/alignerStimulus.txt");
            fileErrors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0) begin
                n = 0;
            end else if (line.getc(0) == "C") begin
                n = $sscanf(line, "C %h %h %h %h %h %h %d", mask, w[0], w[1], w[2], w[3], g, h);
                cmd = '0;
                cmd.mask = mask;
                for (i = 0; i < NUM_LANES; i++) begin
                    cmd.words.lane[i] = w[i];
                end
                cmd.grab = g[0];
                cmd.hold = h;
                if (n != 7) begin
                    $display("Malformed command line in the stimulus file: %s", line);
                    fileErrors++;
                end else begin
                    commands.push_back(cmd);
                    cycleLimit += h;
                end
            end else if (line.getc(0) == "F") begin
                n = $sscanf(line, "F %h", mask);
                cmd = '0;
                cmd.isFlag = 1'b1;
                cmd.mask = mask;
                commands.push_back(cmd);
                cycleLimit += 1;
            end else if (line.getc(0) == "T") begin
                n = $sscanf(line, "T %d %d %d %d %d", expectSets,
                            left[0], left[1], left[2], left[3]);
                for (i = 0; i < NUM_LANES; i++) begin
                    expectLeft[i] = left[i];
                end
                haveTotal = (n == 5);
            end
        end
        $fclose(fd);
        if (!haveTotal) begin
            $display("The stimulus file has no valid closing line");
            fileErrors++;
        end
        cycleLimit += 200;
        limitReady = 1'b1;
    endtask

    // Starts and ends on a falling edge, each held cycle bumps the lane words by one
    task automatic runCommand(input command_t cmd);
        int k;
        int i;
        if (cmd.isFlag) begin
            laneWrite = '0;
            grab = 1'b0;
            flagExpect = cmd.mask;
            flagCheck = 1'b1;
            @(negedge clk);
            flagCheck = 1'b0;
        end else begin
            for (k = 0; k < cmd.hold; k++) begin
                laneWrite = cmd.mask;
                grab = cmd.grab;
                for (i = 0; i < NUM_LANES; i++) begin
                    laneData.lane[i] = cmd.words.lane[i] + laneWord_t'(k);
                end
                @(negedge clk);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        laneWrite = '0;
        laneData = '0;
        grab = 1'b0;
        flagCheck = 1'b0;
        flagExpect = '0;
        endCheck = 1'b0;
        expectSets = 0;
        expectLeft = '0;
        fileErrors = 0;
        cycleCount = 0;
        cycleLimit = 0;
        limitReady = 1'b0;
        loadStimulus();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (commands[c]) begin
            runCommand(commands[c]);
        end
        laneWrite = '0;
        grab = 1'b0;
        endCheck = 1'b1;
        @(negedge clk);
        endCheck = 1'b0;
        @(negedge clk);
        $display("Errors: data %0d, gating %0d, flags %0d, completion %0d, stimulus %0d",
                 dataErrors, gatingErrors, flagErrors, endErrors, fileErrors);
        if (dataErrors + gatingErrors + flagErrors + endErrors + fileErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- bench/alignerChecker.sv
`timescale 1ns/1ns

module alignerChecker
    import laneStreamPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    // DUT ports
    input  laneMask_t                   laneWrite,
    input  laneSet_t                    laneData,
    input  laneMask_t                   laneAlmostFull,
    input  logic                        grab,
    input  logic                        setAvailable,
    input  laneSet_t                    setOut,

    // Check requests from the testbench
    input  logic                        flagCheck,
    input  laneMask_t                   flagExpect,
    input  logic                        endCheck,
    input  int                          expectSets,
    input  logic [NUM_LANES-1:0][15:0]  expectLeft,

    output int                          dataErrors,
    output int                          gatingErrors,
    output int                          flagErrors,
    output int                          endErrors
);

    localparam int MODEL_DEPTH = 1024;

    // Lane queues, each a ring with push and pop counters
    laneWord_t laneWords [NUM_LANES][MODEL_DEPTH];
    int pushCount [NUM_LANES];
    int popCount [NUM_LANES];
    int setsTaken;

    // Cycles in a row with at least one lane queue empty
    int emptyRun;

    task automatic takeSet();
        laneWord_t expected;
        int i;
        for (i = 0; i < NUM_LANES; i++) begin
            if (popCount[i] == pushCount[i]) begin
                $display("%0t: a set was grabbed while lane %0d had no word left in the model",
                         $time, i);
                dataErrors++;
            end else begin
                expected = laneWords[i][popCount[i] % MODEL_DEPTH];
                if (setOut.lane[i] !== expected) begin
                    $display("[FAIL] %0t: set %0d lane %0d is %h, expected %h",
                             $time, setsTaken, i, setOut.lane[i], expected);
                    dataErrors++;
                end
                popCount[i]++;
            end
        end
        setsTaken++;
    endtask

    task automatic checkGating();
        logic anyEmpty;
        int i;
        anyEmpty = 1'b0;
        for (i = 0; i < NUM_LANES; i++) begin
            if (popCount[i] == pushCount[i]) begin
                anyEmpty = 1'b1;
            end
        end
        emptyRun = anyEmpty ? emptyRun + 1 : 0;
        if (emptyRun > 8 && setAvailable) begin
            $display("[FAIL] %0t: setAvailable is high while a lane queue is empty", $time);
            gatingErrors++;
        end
    endtask

    task automatic checkCompletion();
        int i;
        if (setsTaken != expectSets) begin
            $display("[FAIL] %0t: %0d sets grabbed, expected %0d", $time, setsTaken, expectSets);
            endErrors++;
        end
        for (i = 0; i < NUM_LANES; i++) begin
            if (pushCount[i] - popCount[i] != int'(expectLeft[i])) begin
                $display("[FAIL] %0t: lane %0d holds %0d words, expected %0d",
                         $time, i, pushCount[i] - popCount[i], expectLeft[i]);
                endErrors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                pushCount[i] = 0;
                popCount[i] = 0;
            end
            setsTaken = 0;
            emptyRun = 0;
            dataErrors = 0;
            gatingErrors = 0;
            flagErrors = 0;
            endErrors = 0;
        end else begin
            // Words written on this edge cannot belong to the set taken on it
            if (grab && setAvailable) begin
                takeSet();
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (laneWrite[i]) begin
                    laneWords[i][pushCount[i] % MODEL_DEPTH] = laneData.lane[i];
                    pushCount[i]++;
                end
            end
            checkGating();
            if (flagCheck && laneAlmostFull !== flagExpect) begin
                $display("[FAIL] %0t: laneAlmostFull is %b, expected %b",
                         $time, laneAlmostFull, flagExpect);
                flagErrors++;
            end
            if (endCheck) begin
                checkCompletion();
            end
        end
    end

endmodule

//--- src/laneAligner.sv
`timescale 1ns/1ns

module laneAligner
    import fifoGeometryPkg::*, laneStreamPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Producer side
    input  laneMask_t laneWrite,
    input  laneSet_t  laneData,
    output laneMask_t laneAlmostFull,

    // Consumer side
    input  logic      grab,
    output logic      setAvailable,
    output laneSet_t  setOut
);

    laneAddr_t [NUM_LANES-1:0] writeAddrs;
    laneAddr_t readAddr;
    logic readEnable;
    logic setValid;
    logic setFifoAlmostFull;

    // Words from all lane memories, one per lane
    wire laneSet_t memSet;

    laneSet_t fifoData;
    logic fifoEmpty;
    logic fifoValid;
    logic fifoRead;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLaneMem
        fifoMemory #(
            .ADDR_WIDTH(LANE_DEPTH_LOG2),
            .payload_t(laneWord_t)
        ) laneMemory (
            .clk(clk),
            .writeEnable(laneWrite[i]),
            .writeAddr(writeAddrs[i]),
            .dataIn(laneData.lane[i]),
            .readEnable(readEnable),
            .readAddr(readAddr),
            .dataOut(memSet.lane[i])
        );
    end

    streamSynchronizer synchronizer (
        .clk(clk),
        .rst(rst),
        .writes(laneWrite),
        .writeAddrs(writeAddrs),
        .almostFulls(laneAlmostFull),
        .slowDown(setFifoAlmostFull),
        .readEnable(readEnable),
        .readAddr(readAddr),
        .setValid(setValid)
    );

    fastFifo #(
        .DEPTH_LOG2(SET_DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(SET_MARGIN),
        .payload_t(laneSet_t)
    ) setFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(setValid),
        .dataIn(memSet),
        .almostFull(setFifoAlmostFull),
        .readRequest(fifoRead),
        .dataOut(fifoData),
        .empty(fifoEmpty),
        .dataOutValid(fifoValid)
    );

    fifoOutputReg #(
        .payload_t(laneSet_t)
    ) outputReg (
        .clk(clk),
        .rst(rst),
        .fifoEmpty(fifoEmpty),
        .dataFromFifo(fifoData),
        .dataFromFifoValid(fifoValid),
        .readFromFifo(fifoRead),
        .grab(grab),
        .dataAvailable(setAvailable),
        .dataOut(setOut)
    );

endmodule

//--- src/fifoOutputReg.sv
`timescale 1ns/1ns

module fifoOutputReg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,

    // Towards the FIFO read side
    input  logic     fifoEmpty,
    input  payload_t dataFromFifo,
    input  logic     dataFromFifoValid,
    output logic     readFromFifo,

    // Consumer side
    input  logic     grab,
    output logic     dataAvailable,
    output payload_t dataOut
);

    // A read is on its way, a second one would overwrite it
    logic inFlight;

    // Grab only counts while a set is held
    logic take;

    assign take = grab && dataAvailable;
    assign readFromFifo = !fifoEmpty && (take || (!dataAvailable && !inFlight));

    always_ff @(posedge clk) begin
        if (rst) begin
            dataAvailable <= 1'b0;
            inFlight <= 1'b0;
        end else begin
            if (dataFromFifoValid) begin
                dataAvailable <= 1'b1;
                inFlight <= 1'b0;
            end else if (take) begin
                dataAvailable <= 1'b0;
            end
            // Never together with dataFromFifoValid
            if (readFromFifo) begin
                inFlight <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dataFromFifoValid) begin
            dataOut <= dataFromFifo;
        end
    end

    noOverwriteOfHeldSet: assert property (
        @(posedge clk) disable iff (rst)
        dataFromFifoValid |-> !(dataAvailable && !grab)
    ) else $error("FIFO data arrived while a set was still held");

endmodule

//--- src/fastFifo.sv
`timescale 1ns/1ns

module fastFifo
    import fifoGeometryPkg::*;
#(
    parameter int DEPTH_LOG2 = SET_DEPTH_LOG2,
    parameter int ALMOST_FULL_MARGIN = SET_MARGIN,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,

    // Write side
    input  logic     writeEnable,
    input  payload_t dataIn,
    output logic     almostFull,

    // Read side, dataOut holds the last read entry
    input  logic     readRequest,
    output payload_t dataOut,
    output logic     empty,
    output logic     dataOutValid
);

    logic [DEPTH_LOG2-1:0] writeAddr;
    logic [DEPTH_LOG2-1:0] readAddr;
    logic [DEPTH_LOG2-1:0] writesLeft;

    logic isReading;
    logic memReadEnable;
    logic [SET_READ_LATENCY-1:0] validPipe;

    assign writesLeft = readAddr - writeAddr;

    // readAddr points at the entry read last, writeAddr one past the newest
    assign empty = writesLeft == '1;
    assign isReading = readRequest && !empty;
    assign dataOutValid = validPipe[SET_READ_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            writeAddr <= DEPTH_LOG2'(1);
            readAddr <= '0;
            almostFull <= 1'b0;
            memReadEnable <= 1'b0;
            validPipe <= '0;
        end else begin
            writeAddr <= writeAddr + writeEnable;
            readAddr <= readAddr + isReading;
            almostFull <= writesLeft < ALMOST_FULL_MARGIN;
            // Address moves first, memory reads the new slot a cycle later
            memReadEnable <= isReading;
            validPipe <= {validPipe[SET_READ_LATENCY-2:0], isReading};
        end
    end

    fifoMemory #(
        .ADDR_WIDTH(DEPTH_LOG2),
        .payload_t(payload_t)
    ) setMemory (
        .clk(clk),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .dataIn(dataIn),
        .readEnable(memReadEnable),
        .readAddr(readAddr),
        .dataOut(dataOut)
    );

    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        writeEnable |-> writesLeft != '0
    ) else $error("write into a full FIFO");

endmodule

//--- src/streamSynchronizer.sv
`timescale 1ns/1ns

module streamSynchronizer
    import fifoGeometryPkg::*, laneStreamPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // Write side with one counter per lane
    input  laneMask_t                 writes,
    output laneAddr_t [NUM_LANES-1:0] writeAddrs,
    output laneMask_t                 almostFulls,

    // Read side shared by all lane memories
    input  logic                      slowDown,
    output logic                      readEnable,
    output laneAddr_t                 readAddr,
    output logic                      setValid
);

    // Next slot to release, common to every lane
    laneAddr_t readPtr;

    laneAddr_t [NUM_LANES-1:0] freeWords;
    laneMask_t laneFull;
    laneMask_t hasData;

    // Slot being read still holds an unread word in that lane
    laneMask_t readSlotFilled;

    logic releaseSet;
    logic [1:0] pacePhase;

    // Tracks a read through the memory pipeline
    logic [MEM_LATENCY-1:0] validPipe;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        // One slot stays unused so a full lane differs from an empty one
        assign freeWords[i] = readPtr - writeAddrs[i] - 1'b1;
        assign laneFull[i] = freeWords[i] == '0;
        assign readSlotFilled[i] = writeAddrs[i] != readAddr;

        always_ff @(posedge clk) begin
            if (rst) begin
                writeAddrs[i] <= '0;
                hasData[i] <= 1'b0;
                almostFulls[i] <= 1'b0;
            end else begin
                writeAddrs[i] <= writeAddrs[i] + writes[i];
                hasData[i] <= writeAddrs[i] != readPtr;
                almostFulls[i] <= freeWords[i] < LANE_MARGIN;
            end
        end
    end

    // Release at most one set every three cycles.
    // The gap lets readPtr and hasData settle before the next decision
    always_ff @(posedge clk) begin
        if (rst) begin
            pacePhase <= '0;
            releaseSet <= 1'b0;
            readEnable <= 1'b0;
            readPtr <= '0;
            readAddr <= '0;
            validPipe <= '0;
        end else begin
            pacePhase <= (pacePhase == 2'd2) ? 2'd0 : pacePhase + 2'd1;
            releaseSet <= pacePhase == 2'd0 && !slowDown && &hasData;
            readEnable <= releaseSet;
            if (releaseSet) begin
                readAddr <= readPtr;
                readPtr <= readPtr + 1'b1;
            end
            validPipe <= {validPipe[MEM_LATENCY-2:0], readEnable};
        end
    end

    // Memory output of the released set is ready here
    assign setValid = validPipe[MEM_LATENCY-1];

    noWriteToFullLane: assert property (
        @(posedge clk) disable iff (rst)
        (writes & laneFull) == '0
    ) else $error("write to a lane with no free words");

    // Write counters must still be past the slot under read in every lane
    readNeedsAllLanes: assert property (
        @(posedge clk) disable iff (rst)
        readEnable |-> &readSlotFilled
    ) else $error("set read while a lane was empty");

endmodule

//--- src/fifoMemory.sv
`timescale 1ns/1ns

module fifoMemory #(
    parameter int ADDR_WIDTH = 5,
    parameter type payload_t = logic [7:0]
) (
    input  logic                  clk,

    // Write port
    input  logic                  writeEnable,
    input  logic [ADDR_WIDTH-1:0] writeAddr,
    input  payload_t              dataIn,

    // Read port, two register stages
    input  logic                  readEnable,
    input  logic [ADDR_WIDTH-1:0] readAddr,
    output payload_t              dataOut
);

    payload_t storage [2**ADDR_WIDTH];
    payload_t readStage;

    // Marks a read sitting in readStage
    logic readEnableD;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writeAddr] <= dataIn;
        end
    end

    // Each stage only moves when a read passes through it,
    // so dataOut keeps the last word read
    always_ff @(posedge clk) begin
        readEnableD <= readEnable;
        if (readEnable) begin
            readStage <= storage[readAddr];
        end
        if (readEnableD) begin
            dataOut <= readStage;
        end
    end

    writeAddrKnown: assert property (
        @(posedge clk) writeEnable |-> !$isunknown(writeAddr)
    ) else $error("memory write with unknown address");

endmodule

//--- src/laneStreamPkg.sv
package laneStreamPkg;

    // Number of byte lanes that get aligned
    localparam int NUM_LANES = 4;

    // Width of one lane word
    localparam int LANE_WORD_WIDTH = 8;

    typedef logic [LANE_WORD_WIDTH-1:0] laneWord_t;

    // One bit per lane, for write strobes and almost-full flags
    typedef logic [NUM_LANES-1:0] laneMask_t;

    // One aligned set, lane 0 in the lowest bits
    typedef struct packed {
        laneWord_t [NUM_LANES-1:0] lane;
    } laneSet_t;

endpackage

//--- src/fifoGeometryPkg.sv
package fifoGeometryPkg;

    // Each lane memory holds 32 words
    localparam int LANE_DEPTH_LOG2 = 5;

    // Lane reports almost full below this many free words
    localparam int LANE_MARGIN = 8;

    // Set FIFO holds 16 entries, one of them kept as a gap
    localparam int SET_DEPTH_LOG2 = 4;

    // Room for the sets still travelling from the lane memories
    localparam int SET_MARGIN = 4;

    // Read enable to valid memory output
    localparam int MEM_LATENCY = 2;

    // Accepted read to valid set FIFO output, the extra cycle moves the read address
    localparam int SET_READ_LATENCY = MEM_LATENCY + 1;

    typedef logic [LANE_DEPTH_LOG2-1:0] laneAddr_t;

endpackage
